// ==== source/ic_pkg.sv ====
// Instruction cache package with geometry, shared types and the L2 port format
package ic_pkg;

  // ==================================================
  // Geometry
  // ==================================================
  localparam int VADDR_W     = 32;
  localparam int IC_WAYS     = 2;
  localparam int IC_SETS     = 16;
  localparam int IC_LINE_B   = 16;   // Bytes per line
  localparam int IC_OFFSET_W = 4;
  localparam int IC_INDEX_W  = 4;
  localparam int IC_TAG_W    = VADDR_W - IC_INDEX_W - IC_OFFSET_W;
  localparam int IC_DATA_W   = IC_LINE_B * 8;
  localparam int L2_TAG_W    = 2;

  typedef logic [VADDR_W-1:0]     vaddr_t;
  typedef logic [IC_TAG_W-1:0]    ic_tag_t;
  typedef logic [IC_INDEX_W-1:0]  ic_index_t;
  typedef logic [IC_DATA_W-1:0]   ic_data_t;
  typedef logic [IC_WAYS-1:0]     ic_ways_t;      // One hit bit per way
  typedef logic [0:0]             ic_way_idx_t;
  typedef logic [IC_LINE_B-1:0]   ic_be_t;
  typedef logic [L2_TAG_W-1:0]    l2_tag_t;

  // L2 request tags
  localparam l2_tag_t L2_TAG_FETCH = 2'd0;
  localparam l2_tag_t L2_TAG_PREF  = 2'd1;

  // ==================================================
  // Fetch side
  // ==================================================
  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } ic_req_t;

  typedef struct packed {
    logic     valid;
    logic     miss;
    vaddr_t   vaddr;
    ic_data_t data;
    ic_be_t   be;     // Offset up to end of line
  } ic_resp_t;

  // ==================================================
  // Level-two port
  // ==================================================
  typedef struct packed {
    logic    valid;
    l2_tag_t tag;
    vaddr_t  addr;    // Line aligned
  } l2_req_t;

  typedef struct packed {
    logic     valid;
    l2_tag_t  tag;
    ic_data_t data;
  } l2_resp_t;

  typedef enum logic [1:0] {
    IcIdle,
    IcReq,
    IcResp,
    IcInvalidate
  } ic_state_t;

endpackage

// ==== source/ic_tag_array.sv ====
// Tag memory of one cache way with per-set valid bits and a bulk invalidate
`timescale 1ns/1ns

module ic_tag_array
  import ic_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_clear,
  input  logic      i_wr,
  input  ic_index_t i_addr,
  input  ic_tag_t   i_tag,
  output ic_tag_t   o_tag,
  output logic      o_tag_valid
);

  ic_tag_t            r_tags [IC_SETS];
  logic [IC_SETS-1:0] r_valid;

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tags[i_addr] <= i_tag;
    end
    o_tag <= i_wr ? i_tag : r_tags[i_addr];  // New tag visible on write
  end

  // Clear beats a write in the same cycle
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_clear) begin
      r_valid <= '0;
    end else if (i_wr) begin
      r_valid[i_addr] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_tag_valid <= 1'b0;
    end else begin
      o_tag_valid <= !i_clear & (i_wr | r_valid[i_addr]);
    end
  end

endmodule

// ==== source/ic_data_array.sv ====
// Line memory of one cache way with a write-first registered read
`timescale 1ns/1ns

module ic_data_array
  import ic_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_wr,
  input  ic_index_t i_addr,
  input  ic_data_t  i_data,
  output ic_data_t  o_data
);

  ic_data_t r_mem [IC_SETS];

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_mem[i_addr] <= i_data;  // Full line, no byte enables
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_data <= '0;
    end else if (i_wr) begin
      o_data <= i_data;
    end else begin
      o_data <= r_mem[i_addr];
    end
  end

endmodule

// ==== source/ic_prefetch.sv ====
// Next-line instruction prefetcher with a one-line buffer and array write-back
`timescale 1ns/1ns

module ic_prefetch
  import ic_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  logic     i_fence_i,

  input  logic     i_miss_req_fire,
  input  vaddr_t   i_miss_vaddr,

  output logic     o_pref_req_valid,
  input  logic     i_pref_req_ready,
  output vaddr_t   o_pref_req_addr,

  input  logic     i_pref_resp_valid,
  input  ic_data_t i_pref_resp_data,

  input  vaddr_t   i_s0_search_vaddr,
  output logic     o_s1_search_hit,
  output ic_data_t o_s1_search_data,

  output logic     o_wr_valid,
  input  logic     i_wr_ready,
  output vaddr_t   o_wr_vaddr,
  output ic_data_t o_wr_data
);

  logic     r_req_pend;
  logic     r_wait;      // Prefetch outstanding at L2
  logic     r_drop;      // Response overtaken by a fence
  logic     r_buf_valid;
  logic     r_wr_pend;
  vaddr_t   r_pref_addr;
  vaddr_t   r_buf_addr;
  ic_data_t r_buf_data;
  vaddr_t   r_s1_line;
  logic     w_busy;
  logic     w_req_fire;
  logic     w_start;

  assign w_busy     = r_req_pend | r_wait;
  assign w_req_fire = r_req_pend & i_pref_req_ready;
  assign w_start    = i_miss_req_fire & !w_busy;  // One prefetch in flight at most

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_req_pend  <= 1'b0;
      r_wait      <= 1'b0;
      r_drop      <= 1'b0;
      r_buf_valid <= 1'b0;
      r_wr_pend   <= 1'b0;
    end else begin
      if (w_start) begin
        r_req_pend <= 1'b1;
      end else if (w_req_fire) begin
        r_req_pend <= 1'b0;
        r_wait     <= 1'b1;
      end else if (i_pref_resp_valid) begin
        r_wait <= 1'b0;
      end

      if (i_fence_i) begin
        r_buf_valid <= 1'b0;
        r_wr_pend   <= 1'b0;
        r_drop      <= r_req_pend | (r_wait & !i_pref_resp_valid);
      end else if (i_pref_resp_valid) begin
        r_drop      <= 1'b0;
        r_buf_valid <= !r_drop;
        r_wr_pend   <= !r_drop;
      end else if (r_wr_pend & i_wr_ready) begin
        r_wr_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      r_pref_addr <= {i_miss_vaddr[VADDR_W-1:IC_OFFSET_W], {IC_OFFSET_W{1'b0}}} +
                     vaddr_t'(IC_LINE_B);
    end
    if (i_pref_resp_valid) begin
      r_buf_addr <= r_pref_addr;
      r_buf_data <= i_pref_resp_data;
    end
    r_s1_line <= {i_s0_search_vaddr[VADDR_W-1:IC_OFFSET_W], {IC_OFFSET_W{1'b0}}};
  end

  assign o_pref_req_valid = r_req_pend;
  assign o_pref_req_addr  = r_pref_addr;

  // Buffer lookup for the fetch in S1
  assign o_s1_search_hit  = r_buf_valid & (r_s1_line == r_buf_addr);
  assign o_s1_search_data = r_buf_data;

  assign o_wr_valid = r_wr_pend;
  assign o_wr_vaddr = r_buf_addr;
  assign o_wr_data  = r_buf_data;

endmodule

// ==== source/icache.sv ====
// Two-way L1 instruction cache with a three-stage lookup, miss FSM and prefetcher
`timescale 1ns/1ns

module icache
  import ic_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  logic     i_flush_valid,
  input  logic     i_fence_i,

  input  ic_req_t  i_s0_req,
  output logic     o_s0_ready,

  output ic_resp_t o_s2_resp,

  output l2_req_t  o_l2_req,
  input  logic     i_l2_req_ready,
  input  l2_resp_t i_l2_resp
);

  logic        w_s0_fire;
  vaddr_t      w_arr_vaddr;
  ic_index_t   w_arr_index;
  ic_tag_t     w_arr_tag;
  ic_data_t    w_arr_data;
  logic        w_arr_wr;

  logic        r_s1_valid;
  vaddr_t      r_s1_vaddr;
  ic_ways_t    w_s1_hit_ways;
  ic_data_t    w_s1_data [IC_WAYS];
  logic        w_s1_pref_hit;
  ic_data_t    w_s1_pref_data;

  logic        r_s2_valid;
  vaddr_t      r_s2_vaddr;
  ic_ways_t    r_s2_hit_ways;
  ic_data_t    r_s2_data [IC_WAYS];
  logic        r_s2_pref_hit;
  ic_data_t    r_s2_pref_data;
  ic_data_t    w_s2_way_data;
  logic        w_s2_hit_ok;
  logic        w_s2_miss_start;

  ic_state_t   r_state;
  logic        r_req_pend;   // Normal read not yet accepted by L2
  vaddr_t      r_miss_line;
  logic        w_l2_fetch_fire;
  logic        w_l2_fetch_resp;
  logic        w_fill;
  ic_way_idx_t r_rr_ptr [IC_SETS];

  logic        w_pref_req_valid;
  vaddr_t      w_pref_req_addr;
  logic        w_pref_resp;
  logic        w_pref_wr_valid;
  logic        w_pref_wr_ready;
  vaddr_t      w_pref_wr_vaddr;
  ic_data_t    w_pref_wr_data;
  logic        w_pref_wr_fire;

  assign w_s0_fire  = i_s0_req.valid & o_s0_ready;
  assign o_s0_ready = (r_state == IcIdle);

  // ==================================================
  // Array port arbitration
  // ==================================================
  always_comb begin
    if (w_s0_fire) begin
      w_arr_vaddr = i_s0_req.vaddr;
    end else if (w_l2_fetch_resp) begin
      w_arr_vaddr = r_miss_line;
    end else begin
      w_arr_vaddr = w_pref_wr_vaddr;
    end
  end

  assign w_arr_index     = w_arr_vaddr[IC_OFFSET_W +: IC_INDEX_W];
  assign w_arr_tag       = w_arr_vaddr[VADDR_W-1 -: IC_TAG_W];
  assign w_pref_wr_ready = !(w_s0_fire | w_l2_fetch_resp);
  assign w_pref_wr_fire  = w_pref_wr_valid & w_pref_wr_ready;
  assign w_fill          = w_l2_fetch_resp & (r_state == IcResp);
  assign w_arr_wr        = w_fill | w_pref_wr_fire;
  assign w_arr_data      = w_fill ? i_l2_resp.data : w_pref_wr_data;

  // Round-robin victim per set
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < IC_SETS; i++) begin
        r_rr_ptr[i] <= '0;
      end
    end else if (w_arr_wr) begin
      r_rr_ptr[w_arr_index] <= ~r_rr_ptr[w_arr_index];
    end
  end

  for (genvar way = 0; way < IC_WAYS; way++) begin : g_way
    logic    w_wr;
    ic_tag_t w_tag;
    logic    w_tag_valid;

    assign w_wr = w_arr_wr & (r_rr_ptr[w_arr_index] == ic_way_idx_t'(way));

    ic_tag_array u_tag (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_clear     (i_fence_i),
      .i_wr        (w_wr),
      .i_addr      (w_arr_index),
      .i_tag       (w_arr_tag),
      .o_tag       (w_tag),
      .o_tag_valid (w_tag_valid)
    );

    ic_data_array u_data (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_wr),
      .i_addr    (w_arr_index),
      .i_data    (w_arr_data),
      .o_data    (w_s1_data[way])
    );

    assign w_s1_hit_ways[way] = w_tag_valid & (w_tag == r_s1_vaddr[VADDR_W-1 -: IC_TAG_W]);
  end

  // ==================================================
  // S1 and S2 registers
  // ==================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid    <= 1'b0;
      r_s2_valid    <= 1'b0;
      r_s2_hit_ways <= '0;
      r_s2_pref_hit <= 1'b0;
    end else begin
      r_s1_valid    <= w_s0_fire;
      r_s2_valid    <= r_s1_valid & !i_flush_valid;
      r_s2_hit_ways <= w_s1_hit_ways;
      r_s2_pref_hit <= w_s1_pref_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr     <= i_s0_req.vaddr;
    r_s2_vaddr     <= r_s1_vaddr;
    r_s2_data      <= w_s1_data;
    r_s2_pref_data <= w_s1_pref_data;
  end

  always_comb begin
    w_s2_way_data = '0;
    for (int w = 0; w < IC_WAYS; w++) begin
      w_s2_way_data = w_s2_way_data | (r_s2_data[w] & {IC_DATA_W{r_s2_hit_ways[w]}});
    end
  end

  // Cache hits only count while no miss is in progress
  assign w_s2_hit_ok = r_s2_pref_hit | ((|r_s2_hit_ways) & (r_state == IcIdle));

  assign o_s2_resp.valid = r_s2_valid & !i_flush_valid & w_s2_hit_ok;
  assign o_s2_resp.miss  = r_s2_valid & !i_flush_valid & !w_s2_hit_ok;
  assign o_s2_resp.vaddr = r_s2_vaddr;
  assign o_s2_resp.data  = r_s2_pref_hit ? r_s2_pref_data : w_s2_way_data;
  assign o_s2_resp.be    = ic_be_t'('1) << r_s2_vaddr[IC_OFFSET_W-1:0];

  // ==================================================
  // Miss FSM and L2 port
  // ==================================================
  assign w_s2_miss_start = r_s2_valid & !i_flush_valid & !i_fence_i &
                           (r_state == IcIdle) & !r_s2_pref_hit & !(|r_s2_hit_ways);

  assign w_l2_fetch_fire = r_req_pend & !w_pref_req_valid & i_l2_req_ready;
  assign w_l2_fetch_resp = i_l2_resp.valid & (i_l2_resp.tag == L2_TAG_FETCH);
  assign w_pref_resp     = i_l2_resp.valid & (i_l2_resp.tag == L2_TAG_PREF);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state    <= IcIdle;
      r_req_pend <= 1'b0;
    end else begin
      case (r_state)
        IcIdle: begin
          if (w_s2_miss_start) begin
            r_state    <= IcReq;
            r_req_pend <= 1'b1;
          end
        end
        IcReq: begin
          if (i_fence_i) begin
            r_state <= IcInvalidate;  // Request still goes out from there
          end else if (w_l2_fetch_fire) begin
            r_state <= IcResp;
          end
        end
        IcResp: begin
          if (w_l2_fetch_resp) begin
            r_state <= IcIdle;
          end else if (i_fence_i) begin
            r_state <= IcInvalidate;
          end
        end
        IcInvalidate: begin
          if (w_l2_fetch_resp) begin
            r_state <= IcIdle;        // Line dropped
          end
        end
      endcase
      if (w_l2_fetch_fire) begin
        r_req_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_s2_miss_start) begin
      r_miss_line <= {r_s2_vaddr[VADDR_W-1:IC_OFFSET_W], {IC_OFFSET_W{1'b0}}};
    end
  end

  // Prefetch wins the port
  always_comb begin
    if (w_pref_req_valid) begin
      o_l2_req.valid = 1'b1;
      o_l2_req.tag   = L2_TAG_PREF;
      o_l2_req.addr  = w_pref_req_addr;
    end else begin
      o_l2_req.valid = r_req_pend;
      o_l2_req.tag   = L2_TAG_FETCH;
      o_l2_req.addr  = r_miss_line;
    end
  end

  ic_prefetch u_prefetch (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_fence_i         (i_fence_i),
    .i_miss_req_fire   (w_l2_fetch_fire),
    .i_miss_vaddr      (r_miss_line),
    .o_pref_req_valid  (w_pref_req_valid),
    .i_pref_req_ready  (i_l2_req_ready),
    .o_pref_req_addr   (w_pref_req_addr),
    .i_pref_resp_valid (w_pref_resp),
    .i_pref_resp_data  (i_l2_resp.data),
    .i_s0_search_vaddr (i_s0_req.vaddr),
    .o_s1_search_hit   (w_s1_pref_hit),
    .o_s1_search_data  (w_s1_pref_data),
    .o_wr_valid        (w_pref_wr_valid),
    .i_wr_ready        (w_pref_wr_ready),
    .o_wr_vaddr        (w_pref_wr_vaddr),
    .o_wr_data         (w_pref_wr_data)
  );

endmodule

// ==== tb/tb_icache.sv ====
// Testbench for the L1 instruction cache with an L2 memory model and a response scoreboard
`timescale 1ns/1ns

module tb_icache
  import ic_pkg::*;
();

  localparam logic [1:0] K_MISS = 2'd0;
  localparam logic [1:0] K_HIT  = 2'd1;
  localparam logic [1:0] K_NONE = 2'd2;  // Killed by flush
  localparam int         TMO    = 300;

  typedef struct packed {
    vaddr_t     addr;
    logic [1:0] kind;
    int         due;
  } exp_t;

  typedef struct packed {
    l2_tag_t tag;
    vaddr_t  addr;
    int      due;
  } l2_pend_t;

  logic       i_clk = 1'b0;
  logic       i_reset_n;
  logic       i_flush_valid;
  logic       i_fence_i;
  logic       i_l2_req_ready;
  ic_req_t    i_s0_req;
  logic       o_s0_ready;
  ic_resp_t   o_s2_resp;
  l2_req_t    o_l2_req;
  l2_resp_t   i_l2_resp;

  exp_t       sb [$];
  l2_pend_t   l2_q [$];
  int         norm_cnt [vaddr_t];
  int         pref_cnt [vaddr_t];
  int         cyc;
  int         accept_cnt;
  int         ready_hold;
  logic [1:0] cur_kind;
  logic       prev_stall;
  l2_req_t    prev_req;
  string      test_name;

  icache u_dut (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_flush_valid  (i_flush_valid),
    .i_fence_i      (i_fence_i),
    .i_s0_req       (i_s0_req),
    .o_s0_ready     (o_s0_ready),
    .o_s2_resp      (o_s2_resp),
    .o_l2_req       (o_l2_req),
    .i_l2_req_ready (i_l2_req_ready),
    .i_l2_resp      (i_l2_resp)
  );

  initial begin
    forever #2 i_clk = ~i_clk;
  end

  // Line content rule of the memory
  function automatic ic_data_t line_data(vaddr_t line);
    ic_data_t d;
    for (int k = 0; k < 4; k++) begin
      d[32*k +: 32] = (line + 32'(4 * k)) ^ 32'h5A5A_0000;
    end
    return d;
  endfunction

  function automatic ic_be_t expected_be(vaddr_t addr);
    ic_be_t be;
    for (int b = 0; b < IC_LINE_B; b++) begin
      be[b] = (b >= int'(addr[IC_OFFSET_W-1:0]));
    end
    return be;
  endfunction

  function automatic int norm_reads(vaddr_t a);
    return norm_cnt.exists(a) ? norm_cnt[a] : 0;
  endfunction

  function automatic int pref_reads(vaddr_t a);
    return pref_cnt.exists(a) ? pref_cnt[a] : 0;
  endfunction

  task automatic fail_value(string what, logic [IC_DATA_W-1:0] exp, logic [IC_DATA_W-1:0] act);
    $display("ERROR test=%s check=%s expected=%h actual=%h", test_name, what, exp, act);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic fail_reason(string reason);
    $display("Test %s: %s", test_name, reason);
    $display("Regression failed");
    $fatal(1);
  endtask

  // ==================================================
  // Scoreboard and L2 monitor
  // ==================================================
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      cyc = cyc + 1;
      if (sb.size() > 0 && sb[0].due == cyc) begin
        if (sb[0].kind == K_HIT) begin
          assert (o_s2_resp.valid && !o_s2_resp.miss)
            else fail_value("hit", 128'd2, 128'({o_s2_resp.valid, o_s2_resp.miss}));
          assert (o_s2_resp.vaddr == sb[0].addr)
            else fail_value("vaddr", 128'(sb[0].addr), 128'(o_s2_resp.vaddr));
          assert (o_s2_resp.data == line_data({sb[0].addr[31:4], 4'h0}))
            else fail_value("data", line_data({sb[0].addr[31:4], 4'h0}), o_s2_resp.data);
          assert (o_s2_resp.be == expected_be(sb[0].addr))
            else fail_value("be", 128'(expected_be(sb[0].addr)), 128'(o_s2_resp.be));
        end else if (sb[0].kind == K_MISS) begin
          assert (!o_s2_resp.valid && o_s2_resp.miss)
            else fail_value("miss", 128'd1, 128'({o_s2_resp.valid, o_s2_resp.miss}));
        end else begin
          assert (!o_s2_resp.valid && !o_s2_resp.miss)
            else fail_value("flushed", 128'd0, 128'({o_s2_resp.valid, o_s2_resp.miss}));
        end
        sb.pop_front();
      end else begin
        assert (!o_s2_resp.valid && !o_s2_resp.miss)
          else fail_reason("response appeared with no fetch due");
      end
      if (i_s0_req.valid && o_s0_ready) begin
        sb.push_back(exp_t'{addr: i_s0_req.vaddr, kind: cur_kind, due: cyc + 2});
        accept_cnt = accept_cnt + 1;
      end
      // Payload must hold under back-pressure
      if (prev_stall) begin
        assert (o_l2_req == prev_req) else fail_reason("L2 request changed while stalled");
      end
      prev_stall = o_l2_req.valid && !i_l2_req_ready;
      prev_req   = o_l2_req;
      if (o_l2_req.valid && i_l2_req_ready) begin
        l2_q.push_back(l2_pend_t'{tag: o_l2_req.tag, addr: o_l2_req.addr,
                                  due: cyc + 1 + int'($urandom % 5)});
        if (o_l2_req.tag == L2_TAG_FETCH) begin
          norm_cnt[o_l2_req.addr] = norm_reads(o_l2_req.addr) + 1;
        end else begin
          pref_cnt[o_l2_req.addr] = pref_reads(o_l2_req.addr) + 1;
        end
        ready_hold = int'($urandom % 4);
      end else if (ready_hold > 0) begin
        ready_hold = ready_hold - 1;
      end
    end
  end

  // L2 memory answers the first due entry
  always @(negedge i_clk) begin
    int idx;
    idx = -1;
    i_l2_req_ready  = (ready_hold == 0);
    i_l2_resp.valid = 1'b0;
    for (int i = 0; i < l2_q.size(); i++) begin
      if (idx < 0 && l2_q[i].due <= cyc) idx = i;
    end
    if (idx >= 0) begin
      i_l2_resp.valid = 1'b1;
      i_l2_resp.tag   = l2_q[idx].tag;
      i_l2_resp.data  = line_data(l2_q[idx].addr);
      l2_q.delete(idx);
    end
  end

  // ==================================================
  // Stimulus tasks
  // ==================================================
  task automatic fetch(vaddr_t addr, logic [1:0] kind);
    int start;
    int n;
    start = accept_cnt;
    n = 0;
    i_s0_req.valid = 1'b1;
    i_s0_req.vaddr = addr;
    cur_kind       = kind;
    while (accept_cnt == start) begin
      @(negedge i_clk);
      n++;
      if (n > TMO) fail_reason("fetch was never accepted");
    end
  endtask

  task automatic stop_fetch();
    i_s0_req.valid = 1'b0;
  endtask

  task automatic wait_idle();
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while (quiet < 4) begin
      @(negedge i_clk);
      n++;
      if (n > TMO) fail_reason("cache never returned to idle");
      if (sb.size() == 0 && l2_q.size() == 0 && o_s0_ready && !o_l2_req.valid) quiet++;
      else quiet = 0;
    end
  endtask

  task automatic check_count(string what, int exp, int act);
    assert (exp == act) else fail_value(what, 128'(exp), 128'(act));
  endtask

  initial begin
    vaddr_t b;
    void'($urandom(29));
    cyc            = 0;
    accept_cnt     = 0;
    ready_hold     = 0;
    prev_stall     = 1'b0;
    prev_req       = '0;
    cur_kind       = K_HIT;
    i_reset_n      = 1'b0;
    i_flush_valid  = 1'b0;
    i_fence_i      = 1'b0;
    i_l2_req_ready = 1'b0;
    i_s0_req       = '0;
    i_l2_resp      = '0;
    test_name      = "reset";
    repeat (4) @(negedge i_clk);
    i_reset_n = 1'b1;
    assert (o_s0_ready && !o_s2_resp.valid && !o_s2_resp.miss && !o_l2_req.valid)
      else fail_reason("outputs wrong after reset");

    test_name = "cold_miss";
    fetch(32'h0000_1004, K_MISS);
    stop_fetch();
    wait_idle();
    check_count("normal reads", 1, norm_reads(32'h0000_1000));
    fetch(32'h0000_1004, K_HIT);
    stop_fetch();
    wait_idle();

    test_name = "back_to_back";
    for (int i = 0; i < 4; i++) begin
      fetch(32'h0000_1000 + 32'(4 * i), K_HIT);
    end
    stop_fetch();
    wait_idle();

    test_name = "prefetch";
    check_count("prefetch reads", 1, pref_reads(32'h0000_1010));
    fetch(32'h0000_1018, K_HIT);
    stop_fetch();
    wait_idle();
    check_count("normal reads", 0, norm_reads(32'h0000_1010));

    test_name = "replacement";
    b = 32'h0000_3050;
    for (int i = 0; i < 3; i++) begin
      fetch(b + 32'(256 * i), K_MISS);
      stop_fetch();
      wait_idle();
    end
    fetch(b + 32'd512, K_HIT);
    stop_fetch();
    wait_idle();
    fetch(b, K_MISS);
    stop_fetch();
    wait_idle();

    test_name = "fence";
    fetch(32'h0000_1008, K_HIT);
    stop_fetch();
    wait_idle();
    i_fence_i = 1'b1;
    @(negedge i_clk);
    i_fence_i = 1'b0;
    fetch(32'h0000_1008, K_MISS);
    stop_fetch();
    wait_idle();

    test_name = "flush";
    fetch(32'h0000_100C, K_NONE);
    stop_fetch();
    @(negedge i_clk);
    i_flush_valid = 1'b1;  // Request sits in S2 now
    @(negedge i_clk);
    i_flush_valid = 1'b0;
    wait_idle();

    if (sb.size() != 0) begin
      fail_reason("scoreboard not empty at end");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
source/ic_pkg.sv
source/ic_tag_array.sv
source/ic_data_array.sv
source/ic_prefetch.sv
source/icache.sv
tb/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the icache testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_icache -f flist.f -o sim_icache &&
./obj_dir/sim_icache || exit 1
